// ==== sd_dat_phys.f ====
+incdir+logic
logic/dat_phys_pkg.sv
logic/dat_phys_controller.sv
logic/dat_serializer.sv
logic/dat_deserializer.sv
logic/dat_read_fifo.sv
logic/sd_dat_phys.sv
bench/tb_clock_gen.sv
bench/sd_dat_phys_props.sv
bench/sd_dat_phys_tb.sv

// ==== Bender.yml ====
package:
  name: sd_dat_phys

sources:
  - include_dirs:
      - logic
    files:
      - logic/dat_phys_pkg.sv
      - logic/dat_phys_controller.sv
      - logic/dat_serializer.sv
      - logic/dat_deserializer.sv
      - logic/dat_read_fifo.sv
      - logic/sd_dat_phys.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/tb_clock_gen.sv
      - bench/sd_dat_phys_props.sv
      - bench/sd_dat_phys_tb.sv

// ==== bench/sd_dat_phys_tb.sv ====
`include "dat_phys_consts.svh"

module sd_dat_phys_tb import dat_phys_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [2:0] good_token = 3'b010;
	localparam int total_blocks = 20; // 3 write, 4 + 12 read, 1 timed out
	localparam int block_cycles = 80; // a write block is about 72 cycles
	localparam int watchdog_cycles = total_blocks * block_cycles + 500;

	logic sd_clock;
	logic reset;
	logic strobe_in, ack_in, idle_in, write_read, multiple, fifo_pop, dat_in;
	block_count_t blocks;
	timeout_t timeout_reg;
	dat_word_t tx_word;
	logic serial_ready, complete, ack_out, data_timeout, status_error, tx_word_take;
	logic fifo_empty, dat_out, pad_enable;
	dat_word_t fifo_data;
	dat_word_t read_words[$]; // words the card sent, oldest first
	logic card_silent;

	tb_clock_gen u_clock (.sd_clock);
	sd_dat_phys uut (.*);
	bind sd_dat_phys sd_dat_phys_props u_props (.*);

	task automatic stop_with_failure();
		$display("Testbench failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic send_card_word(dat_word_t word);
		dat_in = 1'b0; // start bit
		for (int b = `DAT_WORD_BITS - 1; b >= 0; b--)
		begin
			@(negedge sd_clock);
			dat_in = word[b];
		end
		@(negedge sd_clock);
		dat_in = 1'b1;
	endtask

	// card answers whenever the host listens on DAT
	task automatic card_model();
		dat_word_t word;
		logic [2:0] token;
		forever
		begin
			@(negedge sd_clock);
			if (uut.enable_stp_wrapper && !card_silent)
			begin
				word = $urandom;
				token = $urandom_range(1) ? good_token : 3'b101;
				if (write_read)
					word[2:0] = token; // status word after a write block
				else
					read_words.push_back(word);
				send_card_word(word);
				while (uut.enable_stp_wrapper)
					@(negedge sd_clock);
				if (write_read)
					check_value("status_error", status_error, token != good_token);
			end
		end
	endtask

	task automatic supply_tx_words();
		forever
		begin
			@(negedge sd_clock);
			if (tx_word_take)
				tx_word = $urandom;
		end
	endtask

	task automatic start_transfer(logic wr, block_count_t count);
		while (!serial_ready)
			@(negedge sd_clock);
		write_read = wr;
		multiple = count != 1;
		blocks = count;
		strobe_in = 1'b1;
		@(negedge sd_clock);
		strobe_in = 1'b0;
	endtask

	task automatic acknowledge();
		while (!complete)
			@(negedge sd_clock);
		repeat ($urandom_range(4, 1))
			@(negedge sd_clock);
		ack_in = 1'b1;
		@(negedge sd_clock);
		ack_in = 1'b0;
	endtask

	task automatic pop_and_check();
		check_value("fifo_empty", fifo_empty, 1'b0);
		check_value("fifo_data", fifo_data, read_words.pop_front());
		fifo_pop = 1'b1;
		@(negedge sd_clock);
		fifo_pop = 1'b0;
	endtask

	always @(negedge sd_clock)
		if (uut.u_props.error_count != 0)
		begin
			$display("a property check failed at %0t ns", $time);
			stop_with_failure();
		end

	initial
	begin : watchdog
		repeat (watchdog_cycles)
			@(posedge sd_clock);
		$display("run did not finish within %0d cycles", watchdog_cycles);
		stop_with_failure();
	end

	initial
	begin : main
		void'($urandom(32'hec7ad6e8));
		reset = 1'b1;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		write_read = 1'b0;
		multiple = 1'b0;
		blocks = '0;
		timeout_reg = '1; // never expires
		tx_word = '0;
		fifo_pop = 1'b0;
		dat_in = 1'b1;
		card_silent = 1'b0;
		fork
			card_model();
			supply_tx_words();
		join_none
		repeat (4)
			@(negedge sd_clock);
		reset = 1'b0;

		start_transfer(1'b1, 3);
		acknowledge();

		start_transfer(1'b0, 4);
		acknowledge();
		while (read_words.size() != 0)
			pop_and_check();
		check_value("fifo_empty", fifo_empty, 1'b1);

		// more blocks than slots, stall with the host idle, then drain
		start_transfer(1'b0, 12);
		while (read_words.size() < `DAT_FIFO_DEPTH)
			@(negedge sd_clock);
		repeat (100)
			@(negedge sd_clock);
		while (!complete)
		begin
			if (!fifo_empty)
				pop_and_check();
			else
				@(negedge sd_clock);
		end
		acknowledge();
		while (read_words.size() != 0)
			pop_and_check();
		check_value("fifo_empty", fifo_empty, 1'b1);

		// silent card, then abort with idle_in
		card_silent = 1'b1;
		timeout_reg = 16'd20;
		start_transfer(1'b0, 1);
		while (!data_timeout)
			@(negedge sd_clock);
		idle_in = 1'b1;
		@(negedge sd_clock);
		idle_in = 1'b0;
		card_silent = 1'b0;
		repeat (2)
			@(negedge sd_clock);

		if (uut.u_props.error_count == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
			stop_with_failure();
	end
endmodule

// ==== bench/sd_dat_phys_props.sv ====
`include "dat_phys_consts.svh"

module sd_dat_phys_props import dat_phys_pkg::*; (
	input logic sd_clock,
	input logic reset,
	input logic idle_in,
	input logic ack_in,
	input logic fifo_pop,
	input timeout_t timeout_reg,
	input dat_word_t tx_word,
	input logic serial_ready,
	input logic complete,
	input logic ack_out,
	input logic data_timeout,
	input logic tx_word_take,
	input logic load_send,
	input logic pad_enable,
	input logic dat_out,
	input logic transmission_complete,
	input logic enable_stp_wrapper,
	input logic fifo_push
);
	timeunit 1ns;
	timeprecision 1ps;

	int error_count = 0;
	dat_word_t sent_word;
	int send_phase; // cycles since load_send rose
	int wait_cycles;
	int held_words;

	task automatic count_failure(string what);
		$error("%s", what);
		error_count++;
	endtask

	always_ff @(posedge sd_clock)
	begin
		if (tx_word_take)
			sent_word <= tx_word;
		send_phase <= load_send ? send_phase + 1 : 0;
		wait_cycles <= enable_stp_wrapper ? wait_cycles + 1 : 0;
		if (reset)
			held_words <= 0;
		else
			held_words <= held_words + int'(fifo_push) - int'(fifo_pop && held_words != 0);
	end

	assert property (@(posedge sd_clock) reset |=> !complete && !ack_out && !load_send &&
		!pad_enable && !tx_word_take && !fifo_push)
		else count_failure("host outputs active during reset");
	assert property (@(posedge sd_clock) $fell(reset) |=> serial_ready)
		else count_failure("serial_ready low after reset");

	// write framing, idle-high load cycle first
	assert property (@(posedge sd_clock) disable iff (reset)
		load_send && send_phase == 1 |-> !dat_out)
		else count_failure("missing start bit");
	assert property (@(posedge sd_clock) disable iff (reset)
		load_send && send_phase >= 2 && send_phase <= 33 |-> dat_out == sent_word[33 - send_phase])
		else count_failure("wrong data bit on dat_out");
	assert property (@(posedge sd_clock) disable iff (reset)
		transmission_complete |-> dat_out && send_phase == 34)
		else count_failure("stop bit missing or frame length wrong");

	assert property (@(posedge sd_clock) disable iff (reset)
		fifo_push |-> held_words < `DAT_FIFO_DEPTH)
		else count_failure("push into a full read FIFO");
	assert property (@(posedge sd_clock) disable iff (reset)
		enable_stp_wrapper |-> data_timeout == (wait_cycles >= timeout_reg))
		else count_failure("data_timeout at the wrong cycle");

	assert property (@(posedge sd_clock) disable iff (reset)
		complete && !ack_in && !idle_in |=> complete)
		else count_failure("complete dropped before ack_in");
	assert property (@(posedge sd_clock) disable iff (reset)
		complete |-> ack_out == ack_in)
		else count_failure("ack_out does not follow ack_in");
	assert property (@(posedge sd_clock) disable iff (reset)
		idle_in |=> serial_ready)
		else count_failure("idle_in did not return the controller to idle");
endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic sd_clock
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int half_period = 20; // 40 ns period

	initial
	begin
		sd_clock = 1'b0;
		forever
			#half_period sd_clock = ~sd_clock;
	end
endmodule

// ==== logic/sd_dat_phys.sv ====
module sd_dat_phys import dat_phys_pkg::*; (
	input logic sd_clock,
	input logic reset,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input logic write_read,
	input logic multiple,
	input block_count_t blocks,
	input timeout_t timeout_reg,
	input dat_word_t tx_word,
	input logic fifo_pop,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic data_timeout,
	output logic status_error,
	output logic tx_word_take,
	output dat_word_t fifo_data,
	output logic fifo_empty,
	input logic dat_in,
	output logic dat_out,
	output logic pad_enable
);
	logic transmission_complete;
	logic reception_complete;
	logic load_send;
	logic enable_pts_wrapper;
	logic enable_stp_wrapper;
	logic reset_wrapper;
	logic fifo_push;
	logic credit_return;
	dat_rx_word_u rx_word;

	dat_phys_controller u_controller (
		.sd_clock, .reset, .strobe_in, .ack_in, .idle_in, .write_read,
		.multiple, .blocks, .timeout_reg, .transmission_complete,
		.reception_complete, .rx_word, .credit_return, .serial_ready,
		.complete, .ack_out, .data_timeout, .status_error, .tx_word_take,
		.reset_wrapper, .load_send, .enable_pts_wrapper, .enable_stp_wrapper,
		.pad_enable, .fifo_push
	);

	dat_serializer u_serializer (
		.sd_clock, .reset, .enable_pts_wrapper, .load_send, .tx_word,
		.dat_out, .transmission_complete
	);

	// also receives the status word after each write block
	dat_deserializer u_deserializer (
		.sd_clock, .reset, .reset_wrapper, .enable_stp_wrapper, .dat_in,
		.rx_word, .reception_complete
	);

	dat_read_fifo u_read_fifo (
		.sd_clock,
		.reset,
		.fifo_push,
		.push_word(rx_word.data),
		.fifo_pop,
		.fifo_data,
		.fifo_empty,
		.credit_return
	);
endmodule

// ==== logic/dat_read_fifo.sv ====
`include "dat_phys_consts.svh"

module dat_read_fifo import dat_phys_pkg::*; (
	input logic sd_clock,
	input logic reset,
	input logic fifo_push,
	input dat_word_t push_word,
	input logic fifo_pop,
	output dat_word_t fifo_data,
	output logic fifo_empty,
	output logic credit_return
);
	localparam int ptr_bits = $clog2(`DAT_FIFO_DEPTH);

	dat_word_t mem [`DAT_FIFO_DEPTH];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits:0] count;
	logic pop_ok;

	assign fifo_empty = count == '0;
	assign pop_ok = fifo_pop && !fifo_empty; // pop on empty is dropped
	assign fifo_data = mem[rd_ptr];
	assign credit_return = pop_ok;

	// space is guaranteed by the credit count upstream
	always_ff @(posedge sd_clock)
	begin
		if (fifo_push)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
			wr_ptr <= '0;
		else if (fifo_push)
		begin
			if (wr_ptr == `DAT_FIFO_DEPTH - 1)
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
			rd_ptr <= '0;
		else if (pop_ok)
		begin
			if (rd_ptr == `DAT_FIFO_DEPTH - 1)
				rd_ptr <= '0;
			else
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
			count <= '0;
		else if (fifo_push && !pop_ok)
			count <= count + 1'b1;
		else if (pop_ok && !fifo_push)
			count <= count - 1'b1;
	end
endmodule

// ==== logic/dat_deserializer.sv ====
`include "dat_phys_consts.svh"

module dat_deserializer import dat_phys_pkg::*; (
	input logic sd_clock,
	input logic reset,
	input logic reset_wrapper,
	input logic enable_stp_wrapper,
	input logic dat_in,
	output dat_rx_word_u rx_word,
	output logic reception_complete
);
	logic [$clog2(`DAT_WORD_BITS)-1:0] bit_cnt;
	logic capturing;

	// start bit detect and bit count
	always_ff @(posedge sd_clock)
	begin
		if (reset || reset_wrapper || !enable_stp_wrapper)
		begin
			capturing <= 1'b0;
			bit_cnt <= '0;
		end
		else if (!capturing)
		begin
			capturing <= !dat_in; // start bit
			bit_cnt <= '0;
		end
		else
		begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == `DAT_WORD_BITS - 1)
				capturing <= 1'b0;
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset || reset_wrapper)
			reception_complete <= 1'b0;
		else
			reception_complete <= enable_stp_wrapper && capturing &&
				(bit_cnt == `DAT_WORD_BITS - 1);
	end

	// msb arrives first
	always_ff @(posedge sd_clock)
	begin
		if (enable_stp_wrapper && capturing)
			rx_word.data <= {rx_word.data[`DAT_WORD_BITS-2:0], dat_in};
	end
endmodule

// ==== logic/dat_serializer.sv ====
`include "dat_phys_consts.svh"

module dat_serializer import dat_phys_pkg::*; (
	input logic sd_clock,
	input logic reset,
	input logic enable_pts_wrapper,
	input logic load_send,
	input dat_word_t tx_word,
	output logic dat_out,
	output logic transmission_complete
);
	// load cycle, start bit, data bits, stop bit
	localparam int frame_last = `DAT_WORD_BITS + 2;

	logic [$clog2(frame_last+1)-1:0] phase;
	dat_word_t shift_reg;
	logic data_phase;

	assign data_phase = (phase >= 2) && (phase < frame_last);

	always_ff @(posedge sd_clock)
	begin
		if (reset || !load_send)
			phase <= '0;
		else if (phase != frame_last)
			phase <= phase + 1'b1;
	end

	// word is in place for the first load_send cycle
	always_ff @(posedge sd_clock)
	begin
		if (enable_pts_wrapper && !load_send)
			shift_reg <= tx_word;
		else if (load_send && data_phase)
			shift_reg <= {shift_reg[`DAT_WORD_BITS-2:0], 1'b0};
	end

	always_comb
	begin
		if (!load_send || phase == 0)
			dat_out = 1'b1; // line idles high
		else if (phase == 1)
			dat_out = 1'b0;
		else if (data_phase)
			dat_out = shift_reg[`DAT_WORD_BITS-1];
		else
			dat_out = 1'b1; // stop bit
	end

	assign transmission_complete = load_send && (phase == frame_last);
endmodule

// ==== logic/dat_phys_controller.sv ====
`include "dat_phys_consts.svh"

module dat_phys_controller import dat_phys_pkg::*; (
	input logic sd_clock,
	input logic reset,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input logic write_read,
	input logic multiple,
	input block_count_t blocks,
	input timeout_t timeout_reg,
	input logic transmission_complete,
	input logic reception_complete,
	input dat_rx_word_u rx_word,
	input logic credit_return,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic data_timeout,
	output logic status_error,
	output logic tx_word_take,
	output logic reset_wrapper,
	output logic load_send,
	output logic enable_pts_wrapper,
	output logic enable_stp_wrapper,
	output logic pad_enable,
	output logic fifo_push
);
	dat_state_t state;
	dat_state_t next_state;
	block_count_t block_cnt;
	block_count_t target_blocks;
	logic [`DAT_BLOCK_BITS:0] blocks_done;
	logic last_block;
	logic waiting;
	timeout_t timeout_cnt;
	credit_t credits;
	logic have_credit;

	assign target_blocks = multiple ? blocks : block_count_t'(1);
	assign blocks_done = block_cnt + 1'b1; // count including the block in flight
	assign last_block = blocks_done >= {1'b0, target_blocks};
	assign have_credit = credits != '0;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
			state <= st_reset;
		else if (idle_in)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_reset:
				next_state = st_idle;
			st_idle:
				if (strobe_in)
				begin
					if (write_read)
						next_state = st_load_write;
					else if (have_credit) // no free slot, hold off the read
						next_state = st_read;
				end
			st_load_write:
				next_state = st_send;
			st_send:
				if (transmission_complete)
					next_state = st_wait_response;
			st_wait_response:
				if (reception_complete)
					next_state = last_block ? st_wait_ack : st_load_write;
			st_read:
				if (reception_complete)
					next_state = st_read_fifo_write;
			st_read_fifo_write:
				next_state = last_block ? st_wait_ack : st_read_wrapper_reset;
			st_read_wrapper_reset:
				if (have_credit)
					next_state = st_read;
			st_wait_ack:
				if (ack_in)
					next_state = st_idle;
			default:
				next_state = st_reset;
		endcase
	end

	// blocks finished in this transfer
	always_ff @(posedge sd_clock)
	begin
		if (reset || state == st_idle)
			block_cnt <= '0;
		else if ((state == st_wait_response && reception_complete) ||
				state == st_read_fifo_write)
			block_cnt <= block_cnt + 1'b1;
	end

	assign waiting = (state == st_read) || (state == st_wait_response);

	always_ff @(posedge sd_clock)
	begin
		if (reset || !waiting)
			timeout_cnt <= '0;
		else if (timeout_cnt != timeout_reg)
			timeout_cnt <= timeout_cnt + 1'b1; // saturates at the limit
	end

	assign data_timeout = timeout_cnt == timeout_reg;

	// one credit per free FIFO slot
	always_ff @(posedge sd_clock)
	begin
		if (reset)
			credits <= credit_t'(`DAT_FIFO_DEPTH);
		else if (fifo_push && !credit_return)
			credits <= credits - 1'b1;
		else if (credit_return && !fifo_push)
			credits <= credits + 1'b1;
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
			status_error <= 1'b0;
		else if (state == st_wait_response && reception_complete)
			status_error <= rx_word.status.token != crc_status_positive;
		else if (strobe_in)
			status_error <= 1'b0;
	end

	assign serial_ready = state == st_idle;
	assign complete = state == st_wait_ack;
	assign ack_out = (state == st_wait_ack) && ack_in;
	assign tx_word_take = state == st_load_write;
	assign load_send = state == st_send;
	assign enable_pts_wrapper = (state == st_load_write) || (state == st_send);
	assign pad_enable = (state == st_load_write) || (state == st_send); // host drives DAT
	assign enable_stp_wrapper = waiting;
	assign reset_wrapper = (state == st_reset) || (state == st_read_wrapper_reset);
	assign fifo_push = state == st_read_fifo_write;
endmodule

// ==== logic/dat_phys_pkg.sv ====
`include "dat_phys_consts.svh"

package dat_phys_pkg;
	typedef logic [`DAT_WORD_BITS-1:0] dat_word_t;
	typedef logic [`DAT_BLOCK_BITS-1:0] block_count_t;
	typedef logic [`DAT_TIMEOUT_BITS-1:0] timeout_t;
	typedef logic [$clog2(`DAT_FIFO_DEPTH):0] credit_t; // holds 0..depth

	typedef enum logic [3:0] {
		st_reset,
		st_idle,
		st_load_write,
		st_send,
		st_wait_response,
		st_read,
		st_read_fifo_write,
		st_read_wrapper_reset,
		st_wait_ack
	} dat_state_t;

	localparam logic [2:0] crc_status_positive = 3'b010;

	// read data, or the card's status word after a write block
	typedef union packed {
		dat_word_t data;
		struct packed {
			logic [`DAT_WORD_BITS-4:0] reserved;
			logic [2:0] token;
		} status;
	} dat_rx_word_u;
endpackage

// ==== logic/dat_phys_consts.svh ====
`ifndef DAT_PHYS_CONSTS_SVH
`define DAT_PHYS_CONSTS_SVH

// one data word per block
`define DAT_WORD_BITS 32

// read FIFO slots, also the initial credit count
`define DAT_FIFO_DEPTH 8

`define DAT_BLOCK_BITS 4

// timeout register and counter
`define DAT_TIMEOUT_BITS 16

`endif
